/* Makefile */
# Verilator build and run of the data cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= dcache.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* dcache.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/cache_array.sv
hdl/plru_tree.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/dcache_tb_mem.sv
verification/dcache_tb.sv

/* hdl/cache_array.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module cache_array (
    input  logic                      clock,
    input  logic                      reset,
    input  dcache_pkg::addr_t         lookup_addr,
    output logic                      hit,
    output dcache_pkg::way_idx_t      hit_way,
    output dcache_pkg::block_t        hit_block,
    output logic [`DCACHE_WAYS-1:0]   set_valid,
    input  logic                      fill_en,
    input  dcache_pkg::way_idx_t      fill_way,
    input  dcache_pkg::block_t        fill_block,
    input  logic                      store_en,
    input  dcache_pkg::way_idx_t      store_way,
    input  dcache_pkg::byte_sel_t     store_sel,
    input  dcache_pkg::block_t        store_data
);

    dcache_pkg::tag_t       tag_mem   [`DCACHE_SETS][`DCACHE_WAYS];
    dcache_pkg::block_t     data_mem  [`DCACHE_SETS][`DCACHE_WAYS];
    logic [`DCACHE_WAYS-1:0] valid_mem [`DCACHE_SETS];

    dcache_pkg::tag_t       lu_tag;
    dcache_pkg::set_idx_t   lu_set;
    logic [`DCACHE_WAYS-1:0] hit_vec;

    assign lu_tag = lookup_addr[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
    assign lu_set = lookup_addr[`DCACHE_OFFSET_W +: `DCACHE_SET_W];

    // all four tags of the set compared at once
    always_comb begin
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            hit_vec[w] = valid_mem[lu_set][w] && (tag_mem[lu_set][w] == lu_tag);
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_way = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    assign hit       = |hit_vec;
    assign hit_block = data_mem[lu_set][hit_way];
    assign set_valid = valid_mem[lu_set];

    // valid bits, cleared on reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                valid_mem[s] <= '0;
            end
        end else if (fill_en) begin
            valid_mem[lu_set][fill_way] <= 1'b1;
        end
    end

    // tag and data writes
    always_ff @(posedge clock) begin
        if (fill_en) begin
            tag_mem[lu_set][fill_way]  <= lu_tag;
            data_mem[lu_set][fill_way] <= fill_block;
        end else if (store_en) begin
            // merge only the selected byte lanes
            for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
                if (store_sel[b]) begin
                    data_mem[lu_set][store_way][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
    end

    // controller fills only after a miss, so a block never lives in two ways
    a_single_hit: assert property (@(posedge clock) disable iff (reset)
        $onehot0(hit_vec));

    a_fill_on_miss: assert property (@(posedge clock) disable iff (reset)
        fill_en |-> !hit);

endmodule

/* hdl/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// byte address seen by the core
`define DCACHE_ADDR_W       16

// 8-byte blocks, 8 sets of 4 ways
`define DCACHE_BLOCK_BYTES  8
`define DCACHE_SETS         8
`define DCACHE_WAYS         4

// address split, tag | set | offset
`define DCACHE_OFFSET_W     3
`define DCACHE_SET_W        3
`define DCACHE_TAG_W        10

// block address on the memory bus
`define DCACHE_BLK_ADR_W    (`DCACHE_ADDR_W - `DCACHE_OFFSET_W)

// bits per block
`define DCACHE_BLOCK_W      (`DCACHE_BLOCK_BYTES * 8)

// way index width and core word width
`define DCACHE_WAY_W        2
`define DCACHE_WORD_W       32

// pseudo-LRU tree bits per set
`define DCACHE_PLRU_W       3

`endif

/* hdl/dcache_ctrl.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                      clock,
    input  logic                      reset,
    // core side
    input  logic                      req_valid,
    output logic                      req_ready,
    input  logic                      req_write,
    input  dcache_pkg::addr_t         req_addr,
    input  dcache_pkg::mem_size_t     req_size,
    input  logic                      req_signed,
    input  dcache_pkg::word_t         req_wdata,
    output logic                      resp_valid,
    output dcache_pkg::word_t         resp_data,
    // wishbone master
    output logic                      wb_cyc,
    output logic                      wb_stb,
    output logic                      wb_we,
    output dcache_pkg::blk_adr_t      wb_adr,
    output dcache_pkg::block_t        wb_dat_w,
    output dcache_pkg::byte_sel_t     wb_sel,
    input  dcache_pkg::block_t        wb_dat_r,
    input  logic                      wb_ack,
    // cache array
    output dcache_pkg::addr_t         lookup_addr,
    input  logic                      hit,
    input  dcache_pkg::way_idx_t      hit_way,
    input  dcache_pkg::block_t        hit_block,
    input  logic [`DCACHE_WAYS-1:0]   set_valid,
    output logic                      fill_en,
    output dcache_pkg::way_idx_t      fill_way,
    output dcache_pkg::block_t        fill_block,
    output logic                      store_en,
    output dcache_pkg::way_idx_t      store_way,
    output dcache_pkg::byte_sel_t     store_sel,
    output dcache_pkg::block_t        store_data,
    // pseudo-LRU tree
    output dcache_pkg::set_idx_t      lookup_set,
    output logic                      access_en,
    output dcache_pkg::set_idx_t      access_set,
    output dcache_pkg::way_idx_t      access_way,
    input  dcache_pkg::way_idx_t      lru_way
);

    dcache_pkg::ctrl_state_t state, state_next;

    // accepted request
    dcache_pkg::addr_t       addr_q;
    logic                    write_q;
    dcache_pkg::mem_size_t   size_q;
    logic                    signed_q;
    dcache_pkg::word_t       wdata_q;
    dcache_pkg::way_idx_t    victim_q;
    dcache_pkg::block_t      line_q;

    dcache_pkg::way_idx_t    victim_way;
    logic [`DCACHE_OFFSET_W-1:0] offset;
    dcache_pkg::byte_sel_t   lane_sel;
    dcache_pkg::block_t      lane_data;
    logic [7:0]              ld_byte;
    logic [15:0]             ld_half;

    assign offset = addr_q[`DCACHE_OFFSET_W-1:0];

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::IDLE:    if (req_valid) state_next = dcache_pkg::LOOKUP;
            dcache_pkg::LOOKUP: begin
                if (write_q) state_next = dcache_pkg::STORE;
                else if (hit) state_next = dcache_pkg::RESPOND;
                else          state_next = dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL:  if (wb_ack) state_next = dcache_pkg::FILL;
            dcache_pkg::FILL:    state_next = dcache_pkg::RESPOND;
            dcache_pkg::STORE:   if (wb_ack) state_next = dcache_pkg::IDLE;
            default:             state_next = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clock) begin
        if (state == dcache_pkg::IDLE && req_valid) begin
            addr_q   <= req_addr;
            write_q  <= req_write;
            size_q   <= req_size;
            signed_q <= req_signed;
            wdata_q  <= req_wdata;
        end
        if (state == dcache_pkg::LOOKUP) begin
            line_q   <= hit_block;
            victim_q <= victim_way;
        end
        if (state == dcache_pkg::REFILL && wb_ack) begin
            line_q <= wb_dat_r;
        end
    end

    // lowest invalid way first, tree choice when the set is full
    always_comb begin
        victim_way = lru_way;
        for (int w = `DCACHE_WAYS-1; w >= 0; w--) begin
            if (!set_valid[w]) begin
                victim_way = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    // byte lanes of a store within the block
    always_comb begin
        case (size_q)
            dcache_pkg::BYTE: lane_sel = 8'h01 << offset;
            dcache_pkg::HALF: lane_sel = 8'h03 << offset;
            default:          lane_sel = 8'h0f << offset;
        endcase
    end

    assign lane_data = dcache_pkg::block_t'(wdata_q) << {offset, 3'b000};

    assign lookup_addr = addr_q;
    assign lookup_set  = addr_q[`DCACHE_OFFSET_W +: `DCACHE_SET_W];

    assign fill_en    = (state == dcache_pkg::FILL);
    assign fill_way   = victim_q;
    assign fill_block = line_q;

    // write-through, cached copy updated only on a hit
    assign store_en   = (state == dcache_pkg::LOOKUP) && write_q && hit;
    assign store_way  = hit_way;
    assign store_sel  = lane_sel;
    assign store_data = lane_data;

    assign access_en  = ((state == dcache_pkg::LOOKUP) && hit) || fill_en;
    assign access_set = lookup_set;
    assign access_way = fill_en ? victim_q : hit_way;

    assign wb_cyc   = (state == dcache_pkg::REFILL) || (state == dcache_pkg::STORE);
    assign wb_stb   = wb_cyc;
    assign wb_we    = (state == dcache_pkg::STORE);
    assign wb_adr   = addr_q[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W];
    assign wb_dat_w = lane_data;
    assign wb_sel   = wb_we ? lane_sel : '1;

    assign req_ready  = (state == dcache_pkg::IDLE);
    assign resp_valid = (state == dcache_pkg::RESPOND);

    // load alignment and extension
    assign ld_byte = line_q[{offset, 3'b000} +: 8];
    assign ld_half = line_q[{offset[2:1], 4'b0000} +: 16];

    always_comb begin
        case (size_q)
            dcache_pkg::BYTE: resp_data = {{24{signed_q & ld_byte[7]}}, ld_byte};
            dcache_pkg::HALF: resp_data = {{16{signed_q & ld_half[15]}}, ld_half};
            default:          resp_data = line_q[{offset[2], 5'b00000} +: 32];
        endcase
    end

    // request held steady until the slave acks
    a_wb_hold: assert property (@(posedge clock) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_we)));

    a_resp_load_only: assert property (@(posedge clock) disable iff (reset)
        resp_valid |-> !write_q);

endmodule

/* hdl/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    // byte address and its fields
    typedef logic [`DCACHE_ADDR_W-1:0]    addr_t;
    typedef logic [`DCACHE_BLK_ADR_W-1:0] blk_adr_t;
    typedef logic [`DCACHE_TAG_W-1:0]     tag_t;
    typedef logic [`DCACHE_SET_W-1:0]     set_idx_t;
    typedef logic [`DCACHE_WAY_W-1:0]     way_idx_t;

    // data widths
    typedef logic [`DCACHE_BLOCK_W-1:0]     block_t;
    typedef logic [`DCACHE_WORD_W-1:0]      word_t;
    typedef logic [`DCACHE_BLOCK_BYTES-1:0] byte_sel_t;

    // tree state of one set, {b2, b1, b0}
    typedef logic [`DCACHE_PLRU_W-1:0] plru_bits_t;

    // access size of a load or store
    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_t;

    // request FSM of the controller
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOOKUP  = 3'd1,
        REFILL  = 3'd2,
        FILL    = 3'd3,
        STORE   = 3'd4,
        RESPOND = 3'd5
    } ctrl_state_t;

endpackage

/* hdl/dcache_top.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                    clock,
    input  logic                    reset,
    // core side
    input  logic                    req_valid,
    output logic                    req_ready,
    input  logic                    req_write,
    input  dcache_pkg::addr_t       req_addr,
    input  dcache_pkg::mem_size_t   req_size,
    input  logic                    req_signed,
    input  dcache_pkg::word_t       req_wdata,
    output logic                    resp_valid,
    output dcache_pkg::word_t       resp_data,
    // wishbone master
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output dcache_pkg::blk_adr_t    wb_adr,
    output dcache_pkg::block_t      wb_dat_w,
    output dcache_pkg::byte_sel_t   wb_sel,
    input  dcache_pkg::block_t      wb_dat_r,
    input  logic                    wb_ack
);

    // array <-> controller
    dcache_pkg::addr_t       lookup_addr;
    logic                    hit;
    dcache_pkg::way_idx_t    hit_way;
    dcache_pkg::block_t      hit_block;
    logic [`DCACHE_WAYS-1:0] set_valid;
    logic                    fill_en;
    dcache_pkg::way_idx_t    fill_way;
    dcache_pkg::block_t      fill_block;
    logic                    store_en;
    dcache_pkg::way_idx_t    store_way;
    dcache_pkg::byte_sel_t   store_sel;
    dcache_pkg::block_t      store_data;

    // tree <-> controller
    dcache_pkg::set_idx_t    lookup_set;
    logic                    access_en;
    dcache_pkg::set_idx_t    access_set;
    dcache_pkg::way_idx_t    access_way;
    dcache_pkg::way_idx_t    lru_way;

    cache_array u_cache_array (
        .clock(clock), .reset(reset), .lookup_addr(lookup_addr),
        .hit(hit), .hit_way(hit_way), .hit_block(hit_block), .set_valid(set_valid),
        .fill_en(fill_en), .fill_way(fill_way), .fill_block(fill_block),
        .store_en(store_en), .store_way(store_way), .store_sel(store_sel),
        .store_data(store_data)
    );

    plru_tree u_plru_tree (
        .clock(clock), .reset(reset), .lookup_set(lookup_set),
        .access_en(access_en), .access_set(access_set), .access_way(access_way),
        .lru_way(lru_way)
    );

    dcache_ctrl u_dcache_ctrl (
        .clock(clock), .reset(reset),
        .req_valid(req_valid), .req_ready(req_ready), .req_write(req_write),
        .req_addr(req_addr), .req_size(req_size), .req_signed(req_signed),
        .req_wdata(req_wdata), .resp_valid(resp_valid), .resp_data(resp_data),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .lookup_addr(lookup_addr), .hit(hit), .hit_way(hit_way),
        .hit_block(hit_block), .set_valid(set_valid),
        .fill_en(fill_en), .fill_way(fill_way), .fill_block(fill_block),
        .store_en(store_en), .store_way(store_way), .store_sel(store_sel),
        .store_data(store_data),
        .lookup_set(lookup_set), .access_en(access_en), .access_set(access_set),
        .access_way(access_way), .lru_way(lru_way)
    );

endmodule

/* hdl/plru_tree.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module plru_tree (
    input  logic                  clock,
    input  logic                  reset,
    input  dcache_pkg::set_idx_t  lookup_set,
    input  logic                  access_en,
    input  dcache_pkg::set_idx_t  access_set,
    input  dcache_pkg::way_idx_t  access_way,
    output dcache_pkg::way_idx_t  lru_way
);

    // one tree per set, bit 0 is the root
    dcache_pkg::plru_bits_t tree_bits [`DCACHE_SETS];
    dcache_pkg::plru_bits_t cur_bits;

    assign cur_bits = tree_bits[lookup_set];

    // root picks the pair, then b1 or b2 picks inside it
    always_comb begin
        if (!cur_bits[0]) begin
            lru_way = cur_bits[1] ? 2'd1 : 2'd0;
        end else begin
            lru_way = cur_bits[2] ? 2'd3 : 2'd2;
        end
    end

    // point the tree away from the way just used
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                tree_bits[s] <= '0;
            end
        end else if (access_en) begin
            case (access_way)
                2'd0: begin
                    tree_bits[access_set][0] <= 1'b1;
                    tree_bits[access_set][1] <= 1'b1;
                end
                2'd1: begin
                    tree_bits[access_set][0] <= 1'b1;
                    tree_bits[access_set][1] <= 1'b0;
                end
                2'd2: begin
                    tree_bits[access_set][0] <= 1'b0;
                    tree_bits[access_set][2] <= 1'b1;
                end
                default: begin
                    tree_bits[access_set][0] <= 1'b0;
                    tree_bits[access_set][2] <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* verification/dcache_tb.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tb;

    localparam int RESET_CYCLES   = 8;
    localparam int CYCLES_PER_ROW = 20;
    localparam int HIT_LATENCY    = 2;

    // one request and what it should produce
    typedef struct {
        string                 name;
        logic                  write;
        dcache_pkg::addr_t     addr;
        dcache_pkg::mem_size_t size;
        logic                  sgn;
        dcache_pkg::word_t     wdata;
        dcache_pkg::word_t     exp_data;
        dcache_pkg::block_t    exp_block;
        int                    reads;
    } row_t;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  req_valid;
    logic                  req_ready;
    logic                  req_write;
    dcache_pkg::addr_t     req_addr;
    dcache_pkg::mem_size_t req_size;
    logic                  req_signed;
    dcache_pkg::word_t     req_wdata;
    logic                  resp_valid;
    dcache_pkg::word_t     resp_data;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    dcache_pkg::blk_adr_t  wb_adr;
    dcache_pkg::block_t    wb_dat_w;
    dcache_pkg::byte_sel_t wb_sel;
    dcache_pkg::block_t    wb_dat_r;
    logic                  wb_ack;
    int                    read_count;
    int                    write_count;

    row_t       rows[$];
    // reference image of memory, stores applied as the table is built
    logic [7:0] ref_bytes [1 << `DCACHE_ADDR_W];
    int         cycle_count = 0;
    int         cycle_limit = 0;
    int         fail_count  = 0;

    always #4 clock = ~clock;

    dcache_top u_dcache_top (.*);

    dcache_tb_mem u_mem (.*);

    task automatic stop_on_failure(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            stop_on_failure($sformatf("FAIL %s (%s): expected 0x%0h, actual 0x%0h",
                                      name, what, exp, act));
        end
    endtask

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_on_failure($sformatf("timeout: no end of the run after %0d cycles",
                                      cycle_limit));
        end
    end

    function automatic logic [7:0] pattern_byte(input dcache_pkg::addr_t a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic int size_bytes(input dcache_pkg::mem_size_t s);
        case (s)
            dcache_pkg::BYTE: return 1;
            dcache_pkg::HALF: return 2;
            default:          return 4;
        endcase
    endfunction

    // little endian within the block, extended by the signed flag
    function automatic dcache_pkg::word_t expected_load(input dcache_pkg::addr_t a,
                                                        input dcache_pkg::mem_size_t s,
                                                        input logic sgn);
        dcache_pkg::word_t raw;
        raw = '0;
        for (int i = 0; i < size_bytes(s); i++) begin
            raw[8*i +: 8] = ref_bytes[a + dcache_pkg::addr_t'(i)];
        end
        if (sgn && s == dcache_pkg::BYTE) begin
            raw[31:8] = {24{raw[7]}};
        end else if (sgn && s == dcache_pkg::HALF) begin
            raw[31:16] = {16{raw[15]}};
        end
        return raw;
    endfunction

    function automatic dcache_pkg::block_t expected_block(input dcache_pkg::addr_t a);
        dcache_pkg::block_t blk;
        dcache_pkg::addr_t  base;
        base = {a[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], 3'b000};
        for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
            blk[8*b +: 8] = ref_bytes[base + dcache_pkg::addr_t'(b)];
        end
        return blk;
    endfunction

    task automatic add_load(input string name, input dcache_pkg::addr_t a,
                            input dcache_pkg::mem_size_t s, input logic sgn, input int reads);
        row_t r;
        r.name      = name;
        r.write     = 1'b0;
        r.addr      = a;
        r.size      = s;
        r.sgn       = sgn;
        r.wdata     = '0;
        r.exp_data  = expected_load(a, s, sgn);
        r.exp_block = '0;
        r.reads     = reads;
        rows.push_back(r);
    endtask

    task automatic add_store(input string name, input dcache_pkg::addr_t a,
                             input dcache_pkg::mem_size_t s, input dcache_pkg::word_t wdata);
        row_t r;
        for (int i = 0; i < size_bytes(s); i++) begin
            ref_bytes[a + dcache_pkg::addr_t'(i)] = wdata[8*i +: 8];
        end
        r.name      = name;
        r.write     = 1'b1;
        r.addr      = a;
        r.size      = s;
        r.sgn       = 1'b0;
        r.wdata     = wdata;
        r.exp_data  = '0;
        r.exp_block = expected_block(a);
        r.reads     = 0;
        rows.push_back(r);
    endtask

    task automatic build_table();
        dcache_pkg::addr_t ba;
        for (int a = 0; a < (1 << `DCACHE_ADDR_W); a++) begin
            ba = dcache_pkg::addr_t'(a);
            ref_bytes[ba] = pattern_byte(ba);
        end
        // miss, then the same word hits
        add_load("load_miss_word", 16'h0010, dcache_pkg::WORD, 1'b0, 1);
        add_load("load_hit_word", 16'h0010, dcache_pkg::WORD, 1'b0, 0);
        // sizes and sign extension, block 0x00a0 has bit 7 set in every byte
        add_load("load_byte_s_miss", 16'h00a1, dcache_pkg::BYTE, 1'b1, 1);
        add_load("load_byte_u", 16'h00a1, dcache_pkg::BYTE, 1'b0, 0);
        add_load("load_half_s", 16'h00a2, dcache_pkg::HALF, 1'b1, 0);
        add_load("load_half_u", 16'h00a6, dcache_pkg::HALF, 1'b0, 0);
        add_load("load_word_lo", 16'h00a0, dcache_pkg::WORD, 1'b1, 0);
        add_load("load_word_hi", 16'h00a4, dcache_pkg::WORD, 1'b0, 0);
        add_load("load_byte_s_pos", 16'h0013, dcache_pkg::BYTE, 1'b1, 0);
        // store hits merge into the cached block
        add_store("store_hit_byte", 16'h0011, dcache_pkg::BYTE, 32'h0000_00c3);
        add_load("load_after_byte", 16'h0011, dcache_pkg::BYTE, 1'b1, 0);
        add_store("store_hit_half", 16'h0016, dcache_pkg::HALF, 32'h0000_8001);
        add_load("load_after_half", 16'h0014, dcache_pkg::WORD, 1'b0, 0);
        // store miss leaves the cache alone
        add_store("store_miss_word", 16'h0038, dcache_pkg::WORD, 32'hdead_beef);
        add_load("load_after_miss", 16'h0038, dcache_pkg::WORD, 1'b0, 1);
        add_load("load_half_after", 16'h003a, dcache_pkg::HALF, 1'b1, 0);
        // set 5: A 0x0028, B 0x0068, C 0x00a8, D 0x00e8, E 0x0128
        add_load("fill_a", 16'h0028, dcache_pkg::WORD, 1'b0, 1);
        add_load("fill_b", 16'h0068, dcache_pkg::WORD, 1'b0, 1);
        add_load("fill_c", 16'h00a8, dcache_pkg::WORD, 1'b0, 1);
        add_load("fill_d", 16'h00e8, dcache_pkg::WORD, 1'b0, 1);
        add_load("touch_a", 16'h0028, dcache_pkg::WORD, 1'b0, 0);
        add_load("fill_e_evict_c", 16'h0128, dcache_pkg::WORD, 1'b0, 1);
        add_load("touch_a_again", 16'h0028, dcache_pkg::WORD, 1'b0, 0);
        add_load("refill_c_evict_d", 16'h00a8, dcache_pkg::WORD, 1'b0, 1);
        add_load("keep_e", 16'h0128, dcache_pkg::WORD, 1'b0, 0);
        add_load("keep_b", 16'h0068, dcache_pkg::WORD, 1'b0, 0);
        add_load("refill_d_evict_c", 16'h00e8, dcache_pkg::WORD, 1'b0, 1);
        add_load("refill_c_evict_a", 16'h00a8, dcache_pkg::WORD, 1'b0, 1);
        add_load("refill_a_evict_e", 16'h0028, dcache_pkg::WORD, 1'b0, 1);
        add_load("keep_b_again", 16'h0068, dcache_pkg::WORD, 1'b0, 0);
        add_load("refill_e", 16'h0128, dcache_pkg::WORD, 1'b0, 1);
    endtask

    // entered and left on a falling edge
    task automatic apply_row(input row_t r);
        int reads_before;
        int writes_before;
        int latency;
        while (!req_ready) @(negedge clock);
        reads_before  = read_count;
        writes_before = write_count;
        req_valid  = 1'b1;
        req_write  = r.write;
        req_addr   = r.addr;
        req_size   = r.size;
        req_signed = r.sgn;
        req_wdata  = r.wdata;
        // accepted on the rising edge in between
        @(negedge clock);
        req_valid = 1'b0;
        latency   = 1;
        if (!r.write) begin
            while (!resp_valid) begin
                @(negedge clock);
                latency++;
            end
            check_value(r.name, "load data", 64'(r.exp_data), 64'(resp_data));
            check_value(r.name, "block reads", 64'(r.reads), 64'(read_count - reads_before));
            if (r.reads == 0) begin
                check_value(r.name, "hit latency", 64'(HIT_LATENCY), 64'(latency));
            end
        end else begin
            while (!req_ready) begin
                assert (!resp_valid) else begin
                    stop_on_failure($sformatf("%s: load response during a store", r.name));
                end
                @(negedge clock);
            end
            check_value(r.name, "block writes", 64'd1, 64'(write_count - writes_before));
            check_value(r.name, "block reads", 64'd0, 64'(read_count - reads_before));
            check_value(r.name, "memory block", r.exp_block,
                        u_mem.mem[r.addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]]);
        end
    endtask

    initial begin
        void'($urandom(32'hfeec));
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_size   = dcache_pkg::BYTE;
        req_signed = 1'b0;
        req_wdata  = '0;
        build_table();
        cycle_limit = rows.size() * CYCLES_PER_ROW;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        if (fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_on_failure("checks failed before the end of the run");
        end
    end

endmodule

/* verification/dcache_tb_mem.sv */
`timescale 1ns/100ps
`include "dcache_cfg.svh"

module dcache_tb_mem (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  dcache_pkg::blk_adr_t  wb_adr,
    input  dcache_pkg::block_t    wb_dat_w,
    input  dcache_pkg::byte_sel_t wb_sel,
    output dcache_pkg::block_t    wb_dat_r,
    output logic                  wb_ack,
    output int                    read_count,
    output int                    write_count
);

    localparam int NUM_BLOCKS = 1 << `DCACHE_BLK_ADR_W;

    dcache_pkg::block_t mem [NUM_BLOCKS];
    logic               armed;
    logic [1:0]         delay_cnt;

    // byte = low address byte ^ 8'h5a
    initial begin
        dcache_pkg::addr_t byte_addr;
        for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
            for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
                byte_addr = dcache_pkg::addr_t'(blk * `DCACHE_BLOCK_BYTES + b);
                mem[byte_addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W]][8*b +: 8] =
                    byte_addr[7:0] ^ 8'h5a;
            end
        end
        wb_ack      = 1'b0;
        wb_dat_r    = '0;
        read_count  = 0;
        write_count = 0;
    end

    // one cycle to arm, then 0 to 3 wait cycles, then a single-cycle ack
    always @(posedge clock) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            wb_dat_r    <= '0;
            armed       <= 1'b0;
            delay_cnt   <= '0;
            read_count  <= 0;
            write_count <= 0;
        end else if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!armed) begin
                armed     <= 1'b1;
                delay_cnt <= 2'($urandom % 4);
            end else if (delay_cnt != 2'd0) begin
                delay_cnt <= delay_cnt - 2'd1;
            end else begin
                armed  <= 1'b0;
                wb_ack <= 1'b1;
                if (wb_we) begin
                    for (int b = 0; b < `DCACHE_BLOCK_BYTES; b++) begin
                        if (wb_sel[b]) begin
                            mem[wb_adr][8*b +: 8] <= wb_dat_w[8*b +: 8];
                        end
                    end
                    write_count <= write_count + 1;
                end else begin
                    wb_dat_r   <= mem[wb_adr];
                    read_count <= read_count + 1;
                end
            end
        end
    end

endmodule
